// ==== design/eth_core.sv ====
`timescale 1ns/1ns
`include "eth_consts.svh"

module eth_core (
   input  logic                    clk,
   input  logic                    rst,
   input  eth_host_pkg::host_req_t host_req,
   output eth_host_pkg::word_t     data_out,
   output logic                    phy_resetn,
   input  logic                    tx_clk,
   output eth_mii_pkg::mii_tx_t    mii_tx,
   input  logic                    rx_clk,
   input  eth_mii_pkg::mii_rx_t    mii_rx
);

   localparam int RST_CNT_W = $clog2(`ETH_PHY_RST_CYCLES);

   logic                     data_win;
   logic                     host_wr;
   logic                     host_rd;
   logic                     ctrl_we;
   logic                     scratch_we;
   logic                     tx_nbytes_we;
   logic                     rx_nbytes_we;
   logic                     tx_buf_we;
   logic                     send;
   logic                     receive;
   eth_host_pkg::word_t      scratch;
   eth_mii_pkg::byte_count_t tx_nbytes;
   eth_mii_pkg::byte_count_t rx_nbytes;
   eth_mii_pkg::buf_addr_t   host_buf_addr;
   eth_mii_pkg::buf_addr_t   rx_rd_addr;
   eth_mii_pkg::buf_addr_t   rx_rd_addr_q;
   eth_mii_pkg::byte_t       rx_rd_data;
   eth_mii_pkg::buf_addr_t   tx_rd_addr;
   eth_mii_pkg::byte_t       tx_rd_data;
   logic                     rx_wr;
   eth_mii_pkg::buf_addr_t   rx_wr_addr;
   eth_mii_pkg::byte_t       rx_wr_data;
   logic                     tx_ready_int;
   logic                     rx_ready_int;
   logic [1:0]               tx_ready_sync;
   logic [1:0]               rx_ready_sync;
   logic                     tx_ready;
   logic                     rx_ready;
   eth_host_pkg::word_t      reg_rdata;
   logic                     rd_from_buf;
   logic [RST_CNT_W-1:0]     phy_rst_cnt;

   // address decode
   assign data_win      = host_req.addr[`ETH_ADDR_W-1];
   assign host_buf_addr = host_req.addr[`ETH_BUF_AW-1:0];
   assign host_wr       = host_req.sel & host_req.we;
   assign host_rd       = host_req.sel & ~host_req.we;

   // full address compare, so bit 11 must be clear for a register hit
   assign ctrl_we      = host_wr &&
                         host_req.addr == eth_host_pkg::host_addr_t'(`ETH_REG_CONTROL);
   assign scratch_we   = host_wr &&
                         host_req.addr == eth_host_pkg::host_addr_t'(`ETH_REG_SCRATCH);
   assign tx_nbytes_we = host_wr &&
                         host_req.addr == eth_host_pkg::host_addr_t'(`ETH_REG_TX_NBYTES);
   assign rx_nbytes_we = host_wr &&
                         host_req.addr == eth_host_pkg::host_addr_t'(`ETH_REG_RX_NBYTES);
   assign tx_buf_we    = host_wr & data_win;

   assign send    = ctrl_we & host_req.wdata[0];
   assign receive = ctrl_we & host_req.wdata[1];

   always_ff @(posedge clk) begin
      if (scratch_we) begin
         scratch <= host_req.wdata;
      end
      if (tx_nbytes_we) begin
         tx_nbytes <= host_req.wdata[`ETH_BUF_AW-1:0];
      end
      if (rx_nbytes_we) begin
         rx_nbytes <= host_req.wdata[`ETH_BUF_AW-1:0];
      end
      if (host_rd && data_win) begin
         rx_rd_addr_q <= host_buf_addr;
      end
   end

   // rx buffer keeps the last read address so its byte holds between reads
   assign rx_rd_addr = (host_rd && data_win) ? host_buf_addr : rx_rd_addr_q;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         reg_rdata   <= '0;
         rd_from_buf <= 1'b0;
      end else if (host_rd) begin
         rd_from_buf <= data_win;
         case (host_req.addr)
            eth_host_pkg::host_addr_t'(`ETH_REG_STATUS):
               reg_rdata <= {30'd0, rx_ready, tx_ready};
            eth_host_pkg::host_addr_t'(`ETH_REG_SCRATCH):
               reg_rdata <= scratch;
            default:
               reg_rdata <= '0;
         endcase
      end
   end

   assign data_out = rd_from_buf ? {24'd0, rx_rd_data} : reg_rdata;

   // engine ready levels into clk
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         tx_ready_sync <= '0;
         rx_ready_sync <= '0;
         tx_ready      <= 1'b0;
         rx_ready      <= 1'b0;
      end else begin
         tx_ready_sync <= {tx_ready_sync[0], tx_ready_int};
         rx_ready_sync <= {rx_ready_sync[0], rx_ready_int};
         tx_ready      <= phy_resetn & tx_ready_sync[1];
         rx_ready      <= phy_resetn & rx_ready_sync[1];
      end
   end

   // phy held in reset for a fixed count after rst
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         phy_rst_cnt <= '0;
         phy_resetn  <= 1'b0;
      end else if (phy_rst_cnt != RST_CNT_W'(`ETH_PHY_RST_CYCLES - 1)) begin
         phy_rst_cnt <= phy_rst_cnt + 1'b1;
      end else begin
         phy_resetn <= 1'b1;
      end
   end

   eth_dual_clk_ram #(
      .DATA_W(8),
      .ADDR_W(`ETH_BUF_AW)
   ) tx_buffer (
      .clk_a  (clk),
      .we_a   (tx_buf_we),
      .addr_a (host_buf_addr),
      .data_a (host_req.wdata[7:0]),
      .clk_b  (tx_clk),
      .addr_b (tx_rd_addr),
      .data_b (tx_rd_data)
   );

   eth_dual_clk_ram #(
      .DATA_W(8),
      .ADDR_W(`ETH_BUF_AW)
   ) rx_buffer (
      .clk_a  (rx_clk),
      .we_a   (rx_wr),
      .addr_a (rx_wr_addr),
      .data_a (rx_wr_data),
      .clk_b  (clk),
      .addr_b (rx_rd_addr),
      .data_b (rx_rd_data)
   );

   eth_tx tx_i (
      .tx_clk  (tx_clk),
      .rst     (rst),
      .send    (send),
      .clk     (clk),
      .nbytes  (tx_nbytes),
      .ready   (tx_ready_int),
      .rd_addr (tx_rd_addr),
      .rd_data (tx_rd_data),
      .mii_tx  (mii_tx)
   );

   eth_rx rx_i (
      .rx_clk  (rx_clk),
      .rst     (rst),
      .clk     (clk),
      .receive (receive),
      .nbytes  (rx_nbytes),
      .ready   (rx_ready_int),
      .wr      (rx_wr),
      .wr_addr (rx_wr_addr),
      .wr_data (rx_wr_data),
      .mii_rx  (mii_rx)
   );

   // each toggle synchronizer sees one flip per control write
   a_send_pulse: assert property (@(posedge clk) disable iff (rst) send |=> !send)
      else $error("send pulse longer than one cycle");
   a_receive_pulse: assert property (@(posedge clk) disable iff (rst) receive |=> !receive)
      else $error("receive pulse longer than one cycle");

endmodule

// ==== design/eth_dual_clk_ram.sv ====
`timescale 1ns/1ns

module eth_dual_clk_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 11
) (
   input  logic              clk_a,
   input  logic              we_a,
   input  logic [ADDR_W-1:0] addr_a,
   input  logic [DATA_W-1:0] data_a,
   input  logic              clk_b,
   input  logic [ADDR_W-1:0] addr_b,
   output logic [DATA_W-1:0] data_b
);

   logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

   // write side
   always_ff @(posedge clk_a) begin
      if (we_a) begin
         mem[addr_a] <= data_a;
      end
   end

   // read side, data follows addr_b by one clk_b cycle
   always_ff @(posedge clk_b) begin
      data_b <= mem[addr_b];
   end

endmodule

// ==== design/eth_host_pkg.sv ====
`include "eth_consts.svh"

package eth_host_pkg;

   // host register port address
   typedef logic [`ETH_ADDR_W-1:0] host_addr_t;

   // host data word
   typedef logic [31:0] word_t;

   // one host bus cycle
   // sel and we high means write, sel alone means read
   typedef struct packed {
      logic       sel;
      logic       we;
      host_addr_t addr;
      word_t      wdata;
   } host_req_t;

endpackage

// ==== design/eth_mii_pkg.sv ====
`include "eth_consts.svh"

package eth_mii_pkg;

   typedef logic [3:0] nibble_t;
   typedef logic [7:0] byte_t;

   // buffer address and payload length share the buffer width
   typedef logic [`ETH_BUF_AW-1:0] buf_addr_t;
   typedef logic [`ETH_BUF_AW-1:0] byte_count_t;

   // mii transmit pins
   typedef struct packed {
      logic    en;
      nibble_t data;
   } mii_tx_t;

   // mii receive pins
   typedef struct packed {
      logic    dv;
      nibble_t data;
   } mii_rx_t;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_PREAMBLE,
      TX_SFD,
      TX_DATA,
      TX_DONE
   } tx_state_t;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_ARMED,
      RX_PREAMBLE,
      RX_DATA,
      RX_WAIT_END
   } rx_state_t;

endpackage

// ==== design/eth_rx.sv ====
`timescale 1ns/1ns
`include "eth_consts.svh"

module eth_rx (
   input  logic                     rx_clk,
   input  logic                     rst,
   input  logic                     clk,
   input  logic                     receive,
   input  eth_mii_pkg::byte_count_t nbytes,
   output logic                     ready,
   output logic                     wr,
   output eth_mii_pkg::buf_addr_t   wr_addr,
   output eth_mii_pkg::byte_t       wr_data,
   input  eth_mii_pkg::mii_rx_t     mii_rx
);

   logic                     rcv_tgl;
   logic [2:0]               rcv_sync;
   logic                     start;
   logic                     can_start;
   eth_mii_pkg::rx_state_t   state;
   eth_mii_pkg::byte_count_t cnt;
   eth_mii_pkg::byte_count_t len;
   logic                     dv_q;
   eth_mii_pkg::nibble_t     prev;
   // last two nibbles as one byte, low nibble came first
   eth_mii_pkg::byte_t       pair;
   logic                     nib;
   logic                     byte_done;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         rcv_tgl <= 1'b0;
      end else if (receive) begin
         rcv_tgl <= ~rcv_tgl;
      end
   end

   always_ff @(posedge rx_clk, posedge rst) begin
      if (rst) begin
         rcv_sync <= '0;
      end else begin
         rcv_sync <= {rcv_sync[1:0], rcv_tgl};
      end
   end

   assign start     = rcv_sync[2] ^ rcv_sync[1];
   assign can_start = state inside {eth_mii_pkg::RX_IDLE, eth_mii_pkg::RX_WAIT_END};
   assign pair      = {mii_rx.data, prev};
   assign byte_done = state == eth_mii_pkg::RX_DATA && mii_rx.dv && nib;

   always_ff @(posedge rx_clk) begin
      prev <= mii_rx.data;
      if (can_start && start) begin
         len <= nbytes;
      end
      if (byte_done) begin
         wr_addr <= cnt;
         wr_data <= pair;
      end
   end

   always_ff @(posedge rx_clk, posedge rst) begin
      if (rst) begin
         state <= eth_mii_pkg::RX_IDLE;
         ready <= 1'b0;
         wr    <= 1'b0;
         dv_q  <= 1'b0;
         nib   <= 1'b0;
         cnt   <= '0;
      end else begin
         dv_q <= mii_rx.dv;
         wr   <= byte_done;
         case (state)
            eth_mii_pkg::RX_IDLE,
            eth_mii_pkg::RX_WAIT_END: begin
               ready <= ~start;
               if (start) begin
                  state <= eth_mii_pkg::RX_ARMED;
               end else if (!mii_rx.dv) begin
                  state <= eth_mii_pkg::RX_IDLE;
               end
            end
            eth_mii_pkg::RX_ARMED: begin
               // only a fresh frame, never the tail of one in progress
               if (mii_rx.dv && !dv_q) begin
                  state <= eth_mii_pkg::RX_PREAMBLE;
               end
            end
            eth_mii_pkg::RX_PREAMBLE: begin
               if (!mii_rx.dv) begin
                  state <= eth_mii_pkg::RX_ARMED;
               end else if (pair == `ETH_SFD) begin
                  state <= eth_mii_pkg::RX_DATA;
                  nib   <= 1'b0;
                  cnt   <= '0;
               end
            end
            eth_mii_pkg::RX_DATA: begin
               if (!mii_rx.dv) begin
                  // frame ended early
                  state <= eth_mii_pkg::RX_WAIT_END;
               end else begin
                  nib <= ~nib;
                  if (nib) begin
                     cnt <= cnt + 1'b1;
                     if (cnt == eth_mii_pkg::byte_count_t'(len - 1'b1)) begin
                        state <= eth_mii_pkg::RX_WAIT_END;
                     end
                  end
               end
            end
            default: state <= eth_mii_pkg::RX_IDLE;
         endcase
      end
   end

   // a buffer write is always the byte completed in RX_DATA one cycle before
   a_wr_in_data: assert property (@(posedge rx_clk) disable iff (rst)
      $rose(wr) |-> $past(state) == eth_mii_pkg::RX_DATA)
      else $error("rx buffer write outside RX_DATA");

endmodule

// ==== design/eth_tx.sv ====
`timescale 1ns/1ns
`include "eth_consts.svh"

module eth_tx (
   input  logic                     tx_clk,
   input  logic                     rst,
   input  logic                     send,
   input  logic                     clk,
   input  eth_mii_pkg::byte_count_t nbytes,
   output logic                     ready,
   output eth_mii_pkg::buf_addr_t   rd_addr,
   input  eth_mii_pkg::byte_t       rd_data,
   output eth_mii_pkg::mii_tx_t     mii_tx
);

   logic                     send_tgl;
   // bit 2 holds the last level already acted on
   logic [2:0]               send_sync;
   logic                     start;
   eth_mii_pkg::tx_state_t   state;
   eth_mii_pkg::byte_count_t cnt;
   eth_mii_pkg::byte_count_t len;
   eth_mii_pkg::byte_t       cur_byte;
   // 0 sends the low nibble, 1 the high nibble
   logic                     nib;

   // send request flips a level in the host domain
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         send_tgl <= 1'b0;
      end else if (send) begin
         send_tgl <= ~send_tgl;
      end
   end

   always_ff @(posedge tx_clk, posedge rst) begin
      if (rst) begin
         send_sync <= '0;
      end else begin
         send_sync <= {send_sync[1:0], send_tgl};
      end
   end

   assign start = send_sync[2] ^ send_sync[1];

   always_ff @(posedge tx_clk) begin
      if (state == eth_mii_pkg::TX_IDLE && start) begin
         len <= nbytes;
      end
   end

   always_ff @(posedge tx_clk, posedge rst) begin
      if (rst) begin
         state   <= eth_mii_pkg::TX_IDLE;
         ready   <= 1'b0;
         nib     <= 1'b0;
         cnt     <= '0;
         rd_addr <= '0;
      end else begin
         case (state)
            eth_mii_pkg::TX_IDLE: begin
               ready   <= ~start;
               nib     <= 1'b0;
               cnt     <= '0;
               // byte 0 is fetched while the preamble goes out
               rd_addr <= '0;
               if (start) begin
                  state <= eth_mii_pkg::TX_PREAMBLE;
               end
            end
            eth_mii_pkg::TX_PREAMBLE: begin
               nib <= ~nib;
               if (nib) begin
                  if (cnt == eth_mii_pkg::byte_count_t'(`ETH_PREAMBLE_BYTES - 1)) begin
                     cnt   <= '0;
                     state <= eth_mii_pkg::TX_SFD;
                  end else begin
                     cnt <= cnt + 1'b1;
                  end
               end
            end
            eth_mii_pkg::TX_SFD: begin
               nib <= ~nib;
               if (nib) begin
                  state <= eth_mii_pkg::TX_DATA;
               end
            end
            eth_mii_pkg::TX_DATA: begin
               nib <= ~nib;
               // next address goes out during the high nibble
               if (!nib) begin
                  rd_addr <= rd_addr + 1'b1;
               end else if (cnt == eth_mii_pkg::byte_count_t'(len - 1'b1)) begin
                  state <= eth_mii_pkg::TX_DONE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            eth_mii_pkg::TX_DONE: begin
               ready <= 1'b1;
               state <= eth_mii_pkg::TX_IDLE;
            end
            default: state <= eth_mii_pkg::TX_IDLE;
         endcase
      end
   end

   always_comb begin
      case (state)
         eth_mii_pkg::TX_PREAMBLE: cur_byte = `ETH_PREAMBLE;
         eth_mii_pkg::TX_SFD:      cur_byte = `ETH_SFD;
         default:                  cur_byte = rd_data;
      endcase
   end

   assign mii_tx.en   = state inside {eth_mii_pkg::TX_PREAMBLE, eth_mii_pkg::TX_SFD,
                                      eth_mii_pkg::TX_DATA};
   assign mii_tx.data = nib ? cur_byte[7:4] : cur_byte[3:0];

   // idle always follows at least one cycle with tx_en low
   a_idle_gap: assert property (@(posedge tx_clk) disable iff (rst)
      state == eth_mii_pkg::TX_IDLE |-> !mii_tx.en && $past(!mii_tx.en))
      else $error("tx_en high around TX_IDLE");

endmodule

// ==== include/eth_consts.svh ====
`ifndef ETH_CONSTS_SVH
`define ETH_CONSTS_SVH

// host address width, bit 11 selects the buffer window
`define ETH_ADDR_W 12

// buffer address width for 2 KB buffers
`define ETH_BUF_AW 11

// register addresses in the lower window
`define ETH_REG_STATUS    0
`define ETH_REG_CONTROL   1
`define ETH_REG_SCRATCH   2
`define ETH_REG_TX_NBYTES 3
`define ETH_REG_RX_NBYTES 4

// frame start sequence
`define ETH_PREAMBLE_BYTES 7
`define ETH_PREAMBLE       8'h55
`define ETH_SFD            8'hD5

// clk cycles that phy_resetn stays low after reset
`define ETH_PHY_RST_CYCLES 64

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_eth -o tb_eth \
   && ./obj_dir/tb_eth | tee sim.log \
   || { echo "simulation build or run failed"; exit 1; }
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/tb_eth.sv ====
`timescale 1ns/1ns
`include "eth_consts.svh"

module tb_eth;

   localparam int N_TX     = 6;
   localparam int N_RX     = 6;
   localparam int LONG_LEN = 200;
   localparam int OVER_LEN = 32;

   logic                    clk = 1'b0;
   logic                    tx_clk = 1'b0;
   logic                    rx_clk = 1'b0;
   logic                    rst;
   eth_host_pkg::host_req_t host_req;
   eth_host_pkg::word_t     data_out;
   logic                    phy_resetn;
   eth_mii_pkg::mii_tx_t    mii_tx;
   eth_mii_pkg::mii_rx_t    mii_rx;

   integer                  seed = 86;
   int                      tx_len [N_TX];
   int                      rx_len [N_RX];
   longint                  timeout_ns = 0;
   int                      errors = 0;
   int                      errors_at_start = 0;
   int                      tests_run = 0;
   int                      tests_failed = 0;
   string                   test_name;
   // reference copies of both buffers and the scratch register
   eth_mii_pkg::byte_t      tx_model [0:2047];
   eth_mii_pkg::byte_t      rx_model [0:2047];
   eth_host_pkg::word_t     scratch_model;

   always #20 clk = ~clk;

   // tx_clk rises 10 ns into each 40 ns step
   always begin
      #10 tx_clk = 1'b1;
      #20 tx_clk = 1'b0;
      #10;
   end

   // rx_clk rises 25 ns into each step
   always begin
      #5 rx_clk = 1'b0;
      #20 rx_clk = 1'b1;
      #15;
   end

   eth_core dut_i (
      .clk        (clk),
      .rst        (rst),
      .host_req   (host_req),
      .data_out   (data_out),
      .phy_resetn (phy_resetn),
      .tx_clk     (tx_clk),
      .mii_tx     (mii_tx),
      .rx_clk     (rx_clk),
      .mii_rx     (mii_rx)
   );

   tb_eth_phy phy_i (
      .tx_clk (tx_clk),
      .rx_clk (rx_clk),
      .mii_tx (mii_tx),
      .mii_rx (mii_rx)
   );

   function automatic eth_host_pkg::host_addr_t reg_addr(input int r);
      return eth_host_pkg::host_addr_t'(r);
   endfunction

   // bit 11 selects the buffer window
   function automatic eth_host_pkg::host_addr_t buf_addr(input int a);
      return {1'b1, eth_mii_pkg::buf_addr_t'(a)};
   endfunction

   function automatic eth_mii_pkg::byte_t rand_byte();
      return eth_mii_pkg::byte_t'($random(seed));
   endfunction

   function automatic int rand_len(input int max_len);
      return 1 + ($unsigned($random(seed)) % max_len);
   endfunction

   function automatic eth_mii_pkg::byte_t expected_tx_byte(input int i);
      eth_mii_pkg::byte_t b;
      if (i < `ETH_PREAMBLE_BYTES) begin
         b = `ETH_PREAMBLE;
      end else if (i == `ETH_PREAMBLE_BYTES) begin
         b = `ETH_SFD;
      end else begin
         b = tx_model[i - `ETH_PREAMBLE_BYTES - 1];
      end
      return b;
   endfunction

   task automatic write_word(input eth_host_pkg::host_addr_t addr,
                             input eth_host_pkg::word_t data);
      @(negedge clk);
      host_req.sel   = 1'b1;
      host_req.we    = 1'b1;
      host_req.addr  = addr;
      host_req.wdata = data;
      @(negedge clk);
      host_req = '0;
   endtask

   // data_out is registered, so it is taken one cycle after the request
   task automatic read_word(input eth_host_pkg::host_addr_t addr,
                            output eth_host_pkg::word_t data);
      @(negedge clk);
      host_req.sel   = 1'b1;
      host_req.we    = 1'b0;
      host_req.addr  = addr;
      host_req.wdata = '0;
      @(negedge clk);
      host_req = '0;
      data     = data_out;
   endtask

   task automatic expect_equal(input string what, input eth_host_pkg::word_t exp,
                               input eth_host_pkg::word_t got);
      assert (got === exp) else begin
         $display("** Error %s, %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, got);
         errors++;
      end
   endtask

   task automatic expect_true(input bit cond, input string what);
      assert (cond) else begin
         $display("%s: %s", test_name, what);
         errors++;
      end
   endtask

   task automatic wait_status(input int bit_idx, input logic value);
      eth_host_pkg::word_t st;
      read_word(reg_addr(`ETH_REG_STATUS), st);
      while (st[bit_idx] !== value) begin
         read_word(reg_addr(`ETH_REG_STATUS), st);
      end
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d check(s) failed", test_name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   task automatic run_transmit(input int n, input bit check_busy);
      eth_host_pkg::word_t st;
      int                  frames;
      int                  got_len;
      int                  i;
      wait_status(0, 1'b1);
      for (i = 0; i < n; i++) begin
         tx_model[i] = rand_byte();
         write_word(buf_addr(i), eth_host_pkg::word_t'(tx_model[i]));
      end
      write_word(reg_addr(`ETH_REG_TX_NBYTES), n);
      phy_i.clear_capture();
      frames = phy_i.frames_done;
      write_word(reg_addr(`ETH_REG_CONTROL), 32'h1);
      if (check_busy) begin
         // preamble is on the wire, so ready must be low by now
         while (phy_i.captured_count() < 8) begin
            @(negedge clk);
         end
         read_word(reg_addr(`ETH_REG_STATUS), st);
         expect_equal("status bit 0 while sending", 0, eth_host_pkg::word_t'(st[0]));
      end
      while (phy_i.frames_done == frames) begin
         @(negedge clk);
      end
      got_len = phy_i.captured_count();
      expect_equal("frame length", n + 8, got_len);
      expect_true(phy_i.split_frames == 0, "tx_en fell between the two nibbles of a byte");
      for (i = 0; i < n + 8 && i < got_len; i++) begin
         expect_equal($sformatf("frame byte %0d", i),
                      eth_host_pkg::word_t'(expected_tx_byte(i)),
                      eth_host_pkg::word_t'(phy_i.captured_byte(i)));
      end
      wait_status(0, 1'b1);
   endtask

   // bytes past the armed count stay as they were in the model
   task automatic run_receive(input int armed, input int injected);
      eth_mii_pkg::byte_t  b;
      eth_host_pkg::word_t rd;
      int                  i;
      wait_status(1, 1'b1);
      write_word(reg_addr(`ETH_REG_RX_NBYTES), armed);
      write_word(reg_addr(`ETH_REG_CONTROL), 32'h2);
      wait_status(1, 1'b0);
      for (i = 0; i < injected; i++) begin
         b = rand_byte();
         phy_i.queue_rx_byte(b);
         if (i < armed) begin
            rx_model[i] = b;
         end
      end
      phy_i.inject_frame();
      wait_status(1, 1'b1);
      for (i = 0; i < injected; i++) begin
         read_word(buf_addr(i), rd);
         expect_equal($sformatf("rx buffer byte %0d", i),
                      eth_host_pkg::word_t'(rx_model[i]), rd);
      end
   endtask

   initial begin
      longint total;
      wait (timeout_ns > 0);
      total = timeout_ns;
      #(total);
      $display("timeout: the run did not finish within %0d ns", total);
      $display("Something failed");
      $finish;
   end

   initial begin
      eth_host_pkg::word_t rd;
      int                  total;
      int                  i;
      rst      = 1'b1;
      host_req = '0;

      total = LONG_LEN + 2 * OVER_LEN + 3 * 8;
      for (i = 0; i < N_TX; i++) begin
         tx_len[i] = rand_len(64);
         total += tx_len[i] + 8;
      end
      for (i = 0; i < N_RX; i++) begin
         rx_len[i] = rand_len(64);
         total += rx_len[i] + 8;
      end
      timeout_ns = longint'(total) * 100 * 40 + 10000;

      test_name = "reset";
      repeat (5) @(negedge clk);
      expect_true(phy_resetn === 1'b0, "phy_resetn is not low during reset");
      expect_true(mii_tx.en === 1'b0, "tx_en is not low during reset");
      rst = 1'b0;
      repeat (63) @(negedge clk);
      expect_equal("phy_resetn after 63 cycles", 0, eth_host_pkg::word_t'(phy_resetn));
      @(negedge clk);
      expect_equal("phy_resetn after 64 cycles", 1, eth_host_pkg::word_t'(phy_resetn));
      repeat (4) @(negedge clk);
      read_word(reg_addr(`ETH_REG_STATUS), rd);
      expect_equal("status", 3, rd);
      finish_test();

      test_name = "registers";
      for (i = 0; i < 20; i++) begin
         scratch_model = $random(seed);
         write_word(reg_addr(`ETH_REG_SCRATCH), scratch_model);
         read_word(reg_addr(`ETH_REG_SCRATCH), rd);
         expect_equal("scratch", scratch_model, rd);
      end
      for (i = 5; i < 2048; i++) begin
         read_word(reg_addr(i), rd);
         expect_equal($sformatf("register %0d", i), 0, rd);
      end
      finish_test();

      test_name = "transmit";
      for (i = 0; i < N_TX; i++) begin
         run_transmit(tx_len[i], 1'b0);
      end
      finish_test();

      test_name = "receive";
      for (i = 0; i < N_RX; i++) begin
         run_receive(rx_len[i], rx_len[i]);
      end
      finish_test();

      test_name = "busy_and_overrun";
      run_transmit(LONG_LEN, 1'b1);
      run_receive(OVER_LEN, OVER_LEN);
      run_receive(rand_len(16), OVER_LEN);
      finish_test();

      $display("summary: %0d tests run, %0d failed, %0d check errors",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== sim/tb_eth_phy.sv ====
`timescale 1ns/1ns
`include "eth_consts.svh"

module tb_eth_phy (
   input  logic                 tx_clk,
   input  logic                 rx_clk,
   input  eth_mii_pkg::mii_tx_t mii_tx,
   output eth_mii_pkg::mii_rx_t mii_rx
);

   eth_mii_pkg::byte_t   tx_q[$];
   eth_mii_pkg::byte_t   rx_q[$];
   eth_mii_pkg::nibble_t low_nib;
   // set while the low nibble of a byte is held
   logic                 half;
   logic                 en_q;
   int                   frames_done;
   int                   split_frames;

   initial begin
      mii_rx       = '0;
      low_nib      = '0;
      half         = 1'b0;
      en_q         = 1'b0;
      frames_done  = 0;
      split_frames = 0;
   end

   // tx pins change on the rising edge, so they are taken half a cycle later
   always @(negedge tx_clk) begin
      if (mii_tx.en) begin
         if (half) begin
            tx_q.push_back({mii_tx.data, low_nib});
         end else begin
            low_nib = mii_tx.data;
         end
         half = ~half;
      end else if (en_q) begin
         if (half) begin
            split_frames++;
         end
         half = 1'b0;
         frames_done++;
      end
      en_q = mii_tx.en;
   end

   function automatic int captured_count();
      return tx_q.size();
   endfunction

   function automatic eth_mii_pkg::byte_t captured_byte(input int idx);
      return tx_q[idx];
   endfunction

   task automatic clear_capture();
      tx_q.delete();
   endtask

   task automatic queue_rx_byte(input eth_mii_pkg::byte_t b);
      rx_q.push_back(b);
   endtask

   // preamble, delimiter, then the queued payload, low nibble first
   task automatic inject_frame();
      eth_mii_pkg::byte_t b;
      int                 i;
      for (i = 0; i < rx_q.size() + `ETH_PREAMBLE_BYTES + 1; i++) begin
         if (i < `ETH_PREAMBLE_BYTES) begin
            b = `ETH_PREAMBLE;
         end else if (i == `ETH_PREAMBLE_BYTES) begin
            b = `ETH_SFD;
         end else begin
            b = rx_q[i - `ETH_PREAMBLE_BYTES - 1];
         end
         @(negedge rx_clk);
         mii_rx = {1'b1, b[3:0]};
         @(negedge rx_clk);
         mii_rx = {1'b1, b[7:4]};
      end
      @(negedge rx_clk);
      mii_rx = '0;
      rx_q.delete();
   endtask

endmodule

// ==== tb.f ====
+incdir+include
design/eth_host_pkg.sv
design/eth_mii_pkg.sv
design/eth_dual_clk_ram.sv
design/eth_tx.sv
design/eth_rx.sv
design/eth_core.sv
sim/tb_eth_phy.sv
sim/tb_eth.sv
